// ==== source/wed_pkg.sv ====
// Fixed 128-byte descriptor line in two 64-byte beats; CSR fields sit in the low 320 bits

package wed_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int unsigned LINE_BITS = 1024;              // One cache line
  localparam int unsigned HALF_BITS = LINE_BITS / 2;     // One data beat
  localparam int unsigned ADDR_BITS = 64;                // Host address
  localparam int unsigned TAG_BITS  = 4;                 // Read tag

  // Bits taken by the named CSR fields
  localparam int unsigned CSR_USED_BITS = 2 * 32 + 4 * 64;
  localparam int unsigned RESERVED_BITS = LINE_BITS - CSR_USED_BITS;

  // --------------------------------------------------
  // Descriptor layout
  // --------------------------------------------------
  // Packed struct lists MSB first, so vertex_count lands in bit 0
  typedef struct packed {
    logic [RESERVED_BITS-1:0] reserved;             // Upper spare bits
    logic [63:0]              edge_weight_addr;
    logic [63:0]              edge_dst_addr;
    logic [63:0]              edge_src_addr;
    logic [63:0]              vertex_offsets_addr;
    logic [31:0]              edge_count;
    logic [31:0]              vertex_count;         // Low 32 bits of half 0
  } wed_csr_t;

  // Same line seen as two beats or as CSR fields
  typedef union packed {
    logic [1:0][HALF_BITS-1:0] raw;                 // Half 0 in low bits
    wed_csr_t                  csr;
  } wed_line_t;

  // --------------------------------------------------
  // Memory response codes
  // --------------------------------------------------
  typedef enum logic [1:0] {
    RSP_DONE   = 2'd0,   // Read completed
    RSP_FAILED = 2'd1,   // Read failed, retry
    RSP_OTHER  = 2'd2    // Anything else, treated as failure
  } rsp_code_t;

  // --------------------------------------------------
  // Fetch FSM states
  // --------------------------------------------------
  typedef enum logic [2:0] {
    WED_IDLE    = 3'd0,  // Waiting for start
    WED_REQ     = 3'd1,  // Command presented
    WED_WAIT    = 3'd2,  // Read outstanding
    WED_CHECK   = 3'd3,  // Success, retry or error
    WED_DELIVER = 3'd4   // Descriptor presented
  } wed_state_t;

endpackage

// ==== source/wed_control.sv ====
// One read in flight at a time; the 4-bit tag wraps, so traffic 16 attempts old is not filtered
`timescale 1ns/1ps

module wed_control import wed_pkg::*; #(
  parameter int unsigned MAX_RETRIES = 2
) (
  input  logic                 clock,
  input  logic                 rstn,
  // Start request
  input  logic                 start_valid,
  input  logic [ADDR_BITS-1:0] start_address,
  output logic                 start_ready,
  // Read command
  output logic                 cmd_valid,
  output logic [ADDR_BITS-1:0] cmd_address,
  output logic [TAG_BITS-1:0]  cmd_tag,
  input  logic                 cmd_ready,
  // Read response
  input  logic                 rsp_valid,
  input  logic [TAG_BITS-1:0]  rsp_tag,
  input  rsp_code_t            rsp_code,
  // Timer
  output logic                 timer_clear,
  output logic                 timer_run,
  input  logic                 timer_expired,
  // Line assembler
  output logic [TAG_BITS-1:0]  expected_tag,
  output logic                 line_clear,
  output logic                 decode_load,
  input  logic                 line_complete,
  // Descriptor out
  output logic                 wed_valid,
  output logic                 wed_error,
  input  logic                 wed_ready
);

  localparam int unsigned RETRY_BITS = $clog2(MAX_RETRIES + 2);

  wed_state_t            state, next_state;
  logic [ADDR_BITS-1:0]  addr_q;       // Descriptor address for all attempts
  logic [TAG_BITS-1:0]   tag_q;        // Tag of the current attempt
  logic [RETRY_BITS-1:0] retry_cnt;    // Retries used so far
  logic                  rsp_done_q;   // Last attempt ended with RSP_DONE
  logic                  error_q;

  logic start_fire;
  logic cmd_fire;
  logic rsp_hit;
  logic check_ok;
  logic retry_go;
  logic give_up;

  // --------------------------------------------------
  // Events
  // --------------------------------------------------
  assign start_fire = start_valid && start_ready;
  assign cmd_fire   = cmd_valid && cmd_ready;
  assign rsp_hit    = (state == WED_WAIT) && rsp_valid && (rsp_tag == tag_q); // Own tag only

  // Attempt outcome, only meaningful in WED_CHECK
  assign check_ok = (state == WED_CHECK) && rsp_done_q && line_complete;
  assign retry_go = (state == WED_CHECK) && !check_ok &&
                    (retry_cnt < RETRY_BITS'(MAX_RETRIES));
  assign give_up  = (state == WED_CHECK) && !check_ok && !retry_go;

  // --------------------------------------------------
  // Next state
  // --------------------------------------------------
  always_comb begin
    next_state = state;
    case (state)
      WED_IDLE: begin
        if (start_fire) next_state = WED_REQ;
      end
      WED_REQ: begin
        if (cmd_fire) next_state = WED_WAIT;          // Hold under back-pressure
      end
      WED_WAIT: begin
        if (rsp_hit || timer_expired) next_state = WED_CHECK;
      end
      WED_CHECK: begin
        if (retry_go) next_state = WED_REQ;           // Reissue with a fresh tag
        else next_state = WED_DELIVER;                // Good line or out of retries
      end
      WED_DELIVER: begin
        if (wed_ready) next_state = WED_IDLE;
      end
      default: next_state = WED_IDLE;
    endcase
  end

  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      state <= WED_IDLE;
    end else begin
      state <= next_state;
    end
  end

  // --------------------------------------------------
  // Attempt bookkeeping
  // --------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      tag_q      <= '0;
      retry_cnt  <= '0;
      rsp_done_q <= 1'b0;
      error_q    <= 1'b0;
    end else begin
      if (start_fire) begin
        tag_q     <= tag_q + 1'b1;                    // New tag per attempt
        retry_cnt <= '0;
      end else if (retry_go) begin
        tag_q     <= tag_q + 1'b1;
        retry_cnt <= retry_cnt + 1'b1;
      end
      // Response wins over expiry on the same cycle
      if (rsp_hit) begin
        rsp_done_q <= (rsp_code == RSP_DONE);
      end else if ((state == WED_WAIT) && timer_expired) begin
        rsp_done_q <= 1'b0;
      end
      if (check_ok) error_q <= 1'b0;
      else if (give_up) error_q <= 1'b1;
    end
  end

  // Loaded once per start and reused on retries
  always_ff @(posedge clock) begin
    if (start_fire) begin
      addr_q <= start_address;
    end
  end

  // --------------------------------------------------
  // Outputs
  // --------------------------------------------------
  assign start_ready  = (state == WED_IDLE);
  assign cmd_valid    = (state == WED_REQ);
  assign cmd_address  = addr_q;                       // Stable until next start
  assign cmd_tag      = tag_q;
  assign timer_clear  = cmd_fire;                     // Count from zero in WED_WAIT
  assign timer_run    = (state == WED_WAIT);
  assign expected_tag = tag_q;
  assign line_clear   = start_fire || retry_go;       // Empty line before each attempt
  assign decode_load  = check_ok;
  assign wed_valid    = (state == WED_DELIVER);
  assign wed_error    = error_q;

endmodule

// ==== source/wed_timeout_counter.sv ====
// TIMEOUT_CYCLES must be at least 1; expiry fires once per clear, on the last allowed wait cycle
`timescale 1ns/1ps

module wed_timeout_counter #(
  parameter int unsigned TIMEOUT_CYCLES = 64
) (
  input  logic clock,
  input  logic rstn,
  input  logic timer_clear,
  input  logic timer_run,
  output logic timer_expired
);

  // One extra code so the counter can park past the limit
  localparam int unsigned CNT_BITS = $clog2(TIMEOUT_CYCLES + 1);
  localparam logic [CNT_BITS-1:0] LAST_CYCLE = CNT_BITS'(TIMEOUT_CYCLES - 1);
  localparam logic [CNT_BITS-1:0] PARKED     = CNT_BITS'(TIMEOUT_CYCLES);

  logic [CNT_BITS-1:0] wait_cnt;   // Cycles spent running since clear

  // --------------------------------------------------
  // Wait counter
  // --------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wait_cnt <= '0;
    end else if (timer_clear) begin
      wait_cnt <= '0;                                 // Clear beats run
    end else if (timer_run && (wait_cnt != PARKED)) begin
      wait_cnt <= wait_cnt + 1'b1;                    // Saturate at PARKED
    end
  end

  // Single pulse on the TIMEOUT_CYCLES-th running cycle
  assign timer_expired = timer_run && (wait_cnt == LAST_CYCLE);

endmodule

// ==== source/wed_line_assembler.sv ====
// Beats with a foreign tag are dropped; a repeated beat for the same half overwrites the first
`timescale 1ns/1ps

module wed_line_assembler import wed_pkg::*; (
  input  logic                 clock,
  input  logic                 rstn,
  // From control
  input  logic                 line_clear,
  input  logic [TAG_BITS-1:0]  expected_tag,
  input  logic                 decode_load,
  // Data beats
  input  logic                 data_valid,
  input  logic [TAG_BITS-1:0]  data_tag,
  input  logic                 data_half,
  input  logic [HALF_BITS-1:0] data,
  // To control and output
  output logic                 line_complete,
  output wed_csr_t             wed_fields
);

  wed_line_t  line_q;      // Assembled line, raw and CSR views
  logic [1:0] arrived;     // One bit per half
  logic       beat_hit;

  // Only beats for the current attempt count
  assign beat_hit = data_valid && (data_tag == expected_tag);

  // --------------------------------------------------
  // Line storage
  // --------------------------------------------------
  always_ff @(posedge clock) begin
    if (beat_hit) begin
      line_q.raw[data_half] <= data;                  // Either order
    end
  end

  // --------------------------------------------------
  // Arrival tracking
  // --------------------------------------------------
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      arrived <= 2'b00;
    end else if (line_clear) begin
      arrived <= 2'b00;                               // Old attempt traffic discarded
    end else if (beat_hit) begin
      arrived[data_half] <= 1'b1;
    end
  end

  assign line_complete = &arrived;

  // --------------------------------------------------
  // Decoded CSR fields
  // --------------------------------------------------
  // Zeroed per attempt, so an error delivery shows all zeros
  always_ff @(posedge clock or negedge rstn) begin
    if (!rstn) begin
      wed_fields <= '0;
    end else if (line_clear) begin
      wed_fields <= '0;
    end else if (decode_load) begin
      wed_fields <= line_q.csr;                       // Same bits, field view
    end
  end

endmodule

// ==== source/wed_fetch_top.sv ====
// Needs TIMEOUT_CYCLES >= 1; reserved descriptor bits are decoded but not brought out
`timescale 1ns/1ps

module wed_fetch_top import wed_pkg::*; #(
  parameter int unsigned TIMEOUT_CYCLES = 64,
  parameter int unsigned MAX_RETRIES    = 2
) (
  input  logic                 clock,
  input  logic                 rstn,
  // Start
  input  logic                 start_valid,
  input  logic [ADDR_BITS-1:0] start_address,
  output logic                 start_ready,
  // Command
  output logic                 cmd_valid,
  output logic [ADDR_BITS-1:0] cmd_address,
  output logic [TAG_BITS-1:0]  cmd_tag,
  input  logic                 cmd_ready,
  // Data beats
  input  logic                 data_valid,
  input  logic [TAG_BITS-1:0]  data_tag,
  input  logic                 data_half,
  input  logic [HALF_BITS-1:0] data,
  // Response
  input  logic                 rsp_valid,
  input  logic [TAG_BITS-1:0]  rsp_tag,
  input  rsp_code_t            rsp_code,
  // Descriptor out
  output logic                 wed_valid,
  output logic                 wed_error,
  output logic [31:0]          wed_vertex_count,
  output logic [31:0]          wed_edge_count,
  output logic [63:0]          wed_vertex_offsets_addr,
  output logic [63:0]          wed_edge_src_addr,
  output logic [63:0]          wed_edge_dst_addr,
  output logic [63:0]          wed_edge_weight_addr,
  input  logic                 wed_ready
);

  logic                timer_clear, timer_run, timer_expired;
  logic [TAG_BITS-1:0] expected_tag;
  logic                line_clear, decode_load, line_complete;
  wed_csr_t            wed_fields;

  // --------------------------------------------------
  // Blocks
  // --------------------------------------------------
  wed_control #(.MAX_RETRIES(MAX_RETRIES)) wed_control_i (.*);

  wed_timeout_counter #(.TIMEOUT_CYCLES(TIMEOUT_CYCLES)) wed_timeout_counter_i (.*);

  wed_line_assembler wed_line_assembler_i (.*);

  // Named field outputs
  assign wed_vertex_count        = wed_fields.vertex_count;
  assign wed_edge_count          = wed_fields.edge_count;
  assign wed_vertex_offsets_addr = wed_fields.vertex_offsets_addr;
  assign wed_edge_src_addr       = wed_fields.edge_src_addr;
  assign wed_edge_dst_addr       = wed_fields.edge_dst_addr;
  assign wed_edge_weight_addr    = wed_fields.edge_weight_addr;

endmodule

// ==== verification/wed_fetch_props.sv ====
// Bound to every wed_fetch_top instance; rules hold only after the first reset release
`timescale 1ns/1ps

module wed_fetch_props import wed_pkg::*; (
  input logic                 clock,
  input logic                 rstn,
  input logic                 cmd_valid,
  input logic                 cmd_ready,
  input logic [ADDR_BITS-1:0] cmd_address,
  input logic [TAG_BITS-1:0]  cmd_tag,
  input logic                 wed_valid,
  input logic                 wed_ready
);

  // --------------------------------------------------
  // Handshake rules
  // --------------------------------------------------
  cmd_stable: assert property (@(posedge clock) disable iff (!rstn)
    cmd_valid && !cmd_ready |=> $stable(cmd_address) && $stable(cmd_tag))
    else $error("cmd_address or cmd_tag changed under back-pressure");

  wed_hold: assert property (@(posedge clock) disable iff (!rstn)
    wed_valid && !wed_ready |=> wed_valid)
    else $error("wed_valid fell before wed_ready");

  // First cycle out of reset
  cmd_quiet: assert property (@(posedge clock) $rose(rstn) |-> !cmd_valid)
    else $error("cmd_valid high right after reset release");

endmodule

bind wed_fetch_top wed_fetch_props wed_fetch_props_i (.*);

// ==== verification/wed_fetch_tb.sv ====
// Memory is modelled by tasks in the stimulus process; only one fetch is in flight at a time
`timescale 1ns/1ps

module wed_fetch_tb import wed_pkg::*; ();

  localparam int unsigned TIMEOUT_CYCLES = 64;
  localparam int unsigned MAX_RETRIES    = 2;
  localparam int TEST_FETCHES = 8;                       // Five directed plus three random
  localparam int FETCH_BOUND  = (MAX_RETRIES + 1) * (TIMEOUT_CYCLES + 20);
  localparam int CYCLE_LIMIT  = TEST_FETCHES * FETCH_BOUND + 500;   // Reset and margin

  logic clock, rstn;
  logic start_valid, start_ready;
  logic [ADDR_BITS-1:0] start_address, cmd_address;
  logic cmd_valid, cmd_ready;
  logic [TAG_BITS-1:0] cmd_tag, data_tag, rsp_tag;
  logic data_valid, data_half, rsp_valid;
  logic [HALF_BITS-1:0] data;
  rsp_code_t rsp_code;
  logic wed_valid, wed_error, wed_ready;
  logic [31:0] wed_vertex_count, wed_edge_count;
  logic [63:0] wed_vertex_offsets_addr, wed_edge_src_addr;
  logic [63:0] wed_edge_dst_addr, wed_edge_weight_addr;

  int seed = 32'h945078fe;
  int errors, deliveries, cmd_count, cycles;
  int tests_passed, tests_failed, test_num;
  int errors0, deliveries0, cmds0;                      // Snapshot at test start
  logic     cmd_pending;                                // Command still waiting for cmd_ready
  logic     exp_error;
  wed_csr_t exp_fields;
  logic [ADDR_BITS-1:0] cur_address;

  wed_fetch_top #(
    .TIMEOUT_CYCLES(TIMEOUT_CYCLES),
    .MAX_RETRIES(MAX_RETRIES)
  ) wed_fetch_top_i (.*);

  // --------------------------------------------------
  // Clock, cycle limit, command counter
  // --------------------------------------------------
  always #10 clock = ~clock;

  always @(posedge clock) begin
    cycles++;
    if (cycles >= CYCLE_LIMIT) begin
      $display("Timeout: run passed %0d cycles without finishing", CYCLE_LIMIT);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // Each new command presentation counts once, however long it is held
  always @(posedge clock) begin
    if (rstn && cmd_valid && !cmd_pending) cmd_count++;
    cmd_pending <= rstn && cmd_valid && !cmd_ready;
  end

  // --------------------------------------------------
  // Reference and checks
  // --------------------------------------------------
  // CSR fields all sit in half 0, vertex_count at bit 0
  function automatic wed_csr_t ref_decode(input logic [HALF_BITS-1:0] h0, h1);
    wed_csr_t f;
    f.vertex_count        = h0[31:0];
    f.edge_count          = h0[63:32];
    f.vertex_offsets_addr = h0[127:64];
    f.edge_src_addr       = h0[191:128];
    f.edge_dst_addr       = h0[255:192];
    f.edge_weight_addr    = h0[319:256];
    f.reserved            = {h1, h0[HALF_BITS-1:320]};
    return f;
  endfunction

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("Mismatch %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  // Compare at negedge ahead of the handshake edge
  always @(negedge clock) begin
    if (rstn && wed_valid && wed_ready) begin
      deliveries++;
      check_value("wed_error", 64'(exp_error), 64'(wed_error));
      check_value("wed_vertex_count", 64'(exp_fields.vertex_count), 64'(wed_vertex_count));
      check_value("wed_edge_count", 64'(exp_fields.edge_count), 64'(wed_edge_count));
      check_value("wed_vertex_offsets_addr", exp_fields.vertex_offsets_addr,
                  wed_vertex_offsets_addr);
      check_value("wed_edge_src_addr", exp_fields.edge_src_addr, wed_edge_src_addr);
      check_value("wed_edge_dst_addr", exp_fields.edge_dst_addr, wed_edge_dst_addr);
      check_value("wed_edge_weight_addr", exp_fields.edge_weight_addr, wed_edge_weight_addr);
    end
  end

  // --------------------------------------------------
  // Stimulus helpers
  // --------------------------------------------------
  task automatic tick();
    @(posedge clock);
    #2;                                                 // Drive point after the edge
  endtask

  function automatic logic [HALF_BITS-1:0] random_half();
    logic [HALF_BITS-1:0] v;
    for (int i = 0; i < HALF_BITS / 32; i++) v[i*32 +: 32] = $random(seed);
    return v;
  endfunction

  function automatic int random_below(input int n);
    return {$random(seed)} % n;
  endfunction

  task automatic start_fetch(input logic [ADDR_BITS-1:0] addr);
    bit fire;
    cur_address   = addr;
    start_valid   = 1'b1;
    start_address = addr;
    do begin
      fire = start_ready;                               // Stable until next edge
      tick();
    end while (!fire);
    start_valid = 1'b0;
  endtask

  // Memory side: take one command after some back-pressure
  task automatic accept_cmd(input int ready_delay, output logic [TAG_BITS-1:0] tag);
    while (!cmd_valid) tick();
    repeat (ready_delay) tick();
    check_value("cmd_address", cur_address, cmd_address);
    tag       = cmd_tag;
    cmd_ready = 1'b1;
    tick();
    cmd_ready = 1'b0;
  endtask

  task automatic send_beat(input logic [TAG_BITS-1:0] tag, input logic half,
                           input logic [HALF_BITS-1:0] value);
    data_valid = 1'b1;
    data_tag   = tag;
    data_half  = half;
    data       = value;
    tick();
    data_valid = 1'b0;
  endtask

  task automatic send_rsp(input logic [TAG_BITS-1:0] tag, input rsp_code_t code);
    rsp_valid = 1'b1;
    rsp_tag   = tag;
    rsp_code  = code;
    tick();
    rsp_valid = 1'b0;
  endtask

  // Both halves then the response
  // Joint puts the last beat and the response in one cycle
  task automatic send_line(input logic [TAG_BITS-1:0] tag, input logic [HALF_BITS-1:0] h0,
                           input logic [HALF_BITS-1:0] h1, input bit swap, input int gap,
                           input bit joint, input rsp_code_t code);
    send_beat(tag, swap, swap ? h1 : h0);
    repeat (gap) tick();
    if (joint) begin
      rsp_valid = 1'b1;
      rsp_tag   = tag;
      rsp_code  = code;
      send_beat(tag, !swap, swap ? h0 : h1);
      rsp_valid = 1'b0;
    end else begin
      send_beat(tag, !swap, swap ? h0 : h1);
      send_rsp(tag, code);
    end
  endtask

  task automatic take_wed(input int ready_delay);
    while (!wed_valid) tick();
    repeat (ready_delay) tick();
    wed_ready = 1'b1;
    tick();
    wed_ready = 1'b0;
  endtask

  task automatic begin_test();
    test_num++;
    errors0     = errors;
    deliveries0 = deliveries;
    cmds0       = cmd_count;
  endtask

  task automatic end_test(input string name, input int expected_deliveries);
    assert (deliveries - deliveries0 == expected_deliveries) else begin
      $display("Test %0d delivered %0d descriptors instead of %0d", test_num,
               deliveries - deliveries0, expected_deliveries);
      errors++;
    end
    if (errors == errors0) tests_passed++;
    else tests_failed++;
    $display("Test %0d %s %s", test_num, name, (errors == errors0) ? "passed" : "failed");
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    logic [HALF_BITS-1:0] h0, h1;
    logic [TAG_BITS-1:0]  tag_a, tag_b;
    clock = 1'b0;
    rstn = 1'b0;
    cmd_pending = 1'b0;
    start_valid = 1'b0;
    start_address = '0;
    cmd_ready = 1'b0;
    data_valid = 1'b0;
    data_tag = '0;
    data_half = 1'b0;
    data = '0;
    rsp_valid = 1'b0;
    rsp_tag = '0;
    rsp_code = RSP_DONE;
    wed_ready = 1'b0;
    repeat (10) @(posedge clock);
    #2 rstn = 1'b1;
    tick();

    // 1 Normal fetch, wed_valid two cycles after the response
    begin_test();
    h0 = random_half();
    h1 = random_half();
    exp_error  = 1'b0;
    exp_fields = ref_decode(h0, h1);
    start_fetch({$random(seed), $random(seed)});
    accept_cmd(0, tag_a);
    send_line(tag_a, h0, h1, 1'b0, 0, 1'b0, RSP_DONE);
    check_value("wed_valid", 64'h0, 64'(wed_valid));    // One cycle after response
    tick();
    check_value("wed_valid", 64'h1, 64'(wed_valid));
    take_wed(0);
    end_test("normal fetch", 1);

    // 2 Back-pressure, half 1 first, late wed_ready
    begin_test();
    h0 = random_half();
    h1 = random_half();
    exp_fields = ref_decode(h0, h1);
    start_fetch({$random(seed), $random(seed)});
    accept_cmd(6, tag_a);
    send_line(tag_a, h0, h1, 1'b1, 2, 1'b0, RSP_DONE);
    take_wed(5);
    assert (cmd_count - cmds0 == 1) else begin
      $display("Command issued %0d times instead of once", cmd_count - cmds0);
      errors++;
    end
    end_test("back-pressure reorder", 1);

    // 3 Failed response then success
    begin_test();
    h0 = random_half();
    h1 = random_half();
    exp_fields = ref_decode(h0, h1);
    start_fetch({$random(seed), $random(seed)});
    accept_cmd(0, tag_a);
    send_line(tag_a, h0, h1, 1'b0, 0, 1'b0, RSP_FAILED);
    accept_cmd(1, tag_b);
    send_line(tag_b, h0, h1, 1'b0, 1, 1'b0, RSP_DONE);
    assert (tag_a !== tag_b) else begin
      $display("Retry reused command tag %h", tag_b);
      errors++;
    end
    take_wed(0);
    end_test("failed then done", 1);

    // 4 No answer, then stale traffic ahead of the real line
    begin_test();
    h0 = random_half();
    h1 = random_half();
    exp_fields = ref_decode(h0, h1);
    start_fetch({$random(seed), $random(seed)});
    accept_cmd(0, tag_a);
    accept_cmd(0, tag_b);                               // Arrives after the timeout
    send_line(tag_a, ~h0, ~h1, 1'b0, 0, 1'b0, RSP_DONE);
    send_line(tag_b, h0, h1, 1'b1, 0, 1'b1, RSP_DONE);
    take_wed(1);
    end_test("timeout stale reply", 1);

    // 5 Half 1 never arrives, error after all retries
    begin_test();
    h0 = random_half();
    exp_error  = 1'b1;
    exp_fields = '0;
    start_fetch({$random(seed), $random(seed)});
    for (int a = 0; a <= MAX_RETRIES; a++) begin
      accept_cmd(0, tag_a);
      send_beat(tag_a, 1'b0, h0);
      send_rsp(tag_a, RSP_DONE);
    end
    take_wed(0);
    assert (cmd_count - cmds0 == MAX_RETRIES + 1) else begin
      $display("Saw %0d commands before the error delivery", cmd_count - cmds0);
      errors++;
    end
    end_test("missing half", 1);

    // 6 Random descriptors, delays and beat order
    begin_test();
    exp_error = 1'b0;
    for (int n = 0; n < 3; n++) begin
      h0 = random_half();
      h1 = random_half();
      exp_fields = ref_decode(h0, h1);
      start_fetch({$random(seed), $random(seed)});
      accept_cmd(random_below(4), tag_a);
      send_line(tag_a, h0, h1, random_below(2), random_below(4), random_below(2), RSP_DONE);
      take_wed(random_below(4));
    end
    end_test("random descriptors", 3);

    $display("Summary: %0d tests passed, %0d failed, %0d check errors",
             tests_passed, tests_failed, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== build.f ====
source/wed_pkg.sv
source/wed_control.sv
source/wed_timeout_counter.sv
source/wed_line_assembler.sv
source/wed_fetch_top.sv
verification/wed_fetch_props.sv
verification/wed_fetch_tb.sv

// ==== Bender.yml ====
package:
  name: wed_fetch

sources:
  - files:
      - source/wed_pkg.sv
      - source/wed_control.sv
      - source/wed_timeout_counter.sv
      - source/wed_line_assembler.sv
      - source/wed_fetch_top.sv
  - target: test
    files:
      - verification/wed_fetch_props.sv
      - verification/wed_fetch_tb.sv
